/* source/fe_cfg_pkg.sv */
package fe_cfg_pkg;

  // First fetch address after reset
  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  // Instruction memory geometry, in 32-bit words
  localparam int IMEM_WORDS = 256;
  localparam int IMEM_AW = 8;

  // Direct-mapped BTB
  // Index taken from pc[5:2], tag from pc[31:6]
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IW = 4;

endpackage

/* source/fe_types_pkg.sv */
package fe_types_pkg;

  // Byte address and instruction word
  typedef logic [31:0] pc_t;
  typedef logic [31:0] instr_t;

  // Word address into the instruction memory
  typedef logic [fe_cfg_pkg::IMEM_AW-1:0] waddr_t;

  // Next-PC source, lowest to highest priority
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'd0,
    PC_SEL_PREDICTED  = 2'd1,
    PC_SEL_REDIRECT   = 2'd2
  } pc_sel_t;

  // Back-end redirect strobe
  typedef struct packed {
    logic valid;
    pc_t  tgt;
  } redir_t;

  // Installs a taken branch in the BTB
  typedef struct packed {
    logic valid;
    pc_t  pc;
    pc_t  tgt;
  } btb_upd_t;

  // BTB lookup result for the current pc
  typedef struct packed {
    logic hit;
    pc_t  tgt;
  } btb_pred_t;

  // Program loader write
  typedef struct packed {
    logic   we;
    waddr_t addr;
    instr_t data;
  } load_t;

  // Request on the single memory port
  typedef struct packed {
    logic   en;
    logic   we;
    waddr_t addr;
    instr_t data;
  } mem_req_t;

  // Packet handed to decode
  typedef struct packed {
    logic   valid;
    pc_t    pc;
    instr_t instr;
    logic   pred_taken;
  } fetch_pkt_t;

endpackage

/* source/fe_pc_sel.sv */
`timescale 1ns/1ps

module fe_pc_sel (
  input  fe_types_pkg::redir_t    redir_i,
  input  fe_types_pkg::btb_pred_t btb_pred_i,
  output fe_types_pkg::pc_sel_t   pc_sel_o,
  output fe_types_pkg::pc_t       tgt_o
);

  // Fixed priority
  // Redirect from the back end beats a BTB hit, sequential is the fallback
  always_comb begin
    if (redir_i.valid) begin
      pc_sel_o = fe_types_pkg::PC_SEL_REDIRECT;
      tgt_o    = redir_i.tgt;
    end else if (btb_pred_i.hit) begin
      pc_sel_o = fe_types_pkg::PC_SEL_PREDICTED;
      tgt_o    = btb_pred_i.tgt;
    end else begin
      pc_sel_o = fe_types_pkg::PC_SEL_SEQUENTIAL;
      // Target unused on the sequential path, keep the BTB value
      tgt_o    = btb_pred_i.tgt;
    end
  end

endmodule

/* source/fe_btb.sv */
`timescale 1ns/1ps

module fe_btb (
  input  logic                    clk,
  input  logic                    rst_n,
  input  fe_types_pkg::pc_t       pc_i,
  input  fe_types_pkg::btb_upd_t  upd_i,
  output fe_types_pkg::btb_pred_t pred_o
);

  // Per-entry valid bit, tag and target
  logic [fe_cfg_pkg::BTB_ENTRIES-1:0] valid_q;
  logic [31:fe_cfg_pkg::BTB_IW+2]     tag_mem [fe_cfg_pkg::BTB_ENTRIES];
  fe_types_pkg::pc_t                  tgt_mem [fe_cfg_pkg::BTB_ENTRIES];

  logic [fe_cfg_pkg::BTB_IW-1:0] rd_idx;
  logic [fe_cfg_pkg::BTB_IW-1:0] wr_idx;

  // Word-aligned index bits above the byte offset
  assign rd_idx = pc_i[fe_cfg_pkg::BTB_IW+1:2];
  assign wr_idx = upd_i.pc[fe_cfg_pkg::BTB_IW+1:2];

  // Valid bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd_i.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Update overwrites whatever sits at the index
  always_ff @(posedge clk) begin
    if (upd_i.valid) begin
      tag_mem[wr_idx] <= upd_i.pc[31:fe_cfg_pkg::BTB_IW+2];
      tgt_mem[wr_idx] <= upd_i.tgt;
    end
  end

  // Combinational lookup on the current pc
  // An aliasing pc with another tag misses
  always_comb begin
    pred_o.hit = valid_q[rd_idx] &&
                 (tag_mem[rd_idx] == pc_i[31:fe_cfg_pkg::BTB_IW+2]);
    pred_o.tgt = tgt_mem[rd_idx];
  end

endmodule

/* source/fe_pc_stage.sv */
`timescale 1ns/1ps

module fe_pc_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall_i,
  input  logic                  stall_be_i,
  input  fe_types_pkg::pc_sel_t pc_sel_i,
  input  fe_types_pkg::pc_t     tgt_i,
  input  logic                  pred_hit_i,
  output fe_types_pkg::pc_t     pc_o,
  output fe_types_pkg::pc_t     pc_if_o,
  output logic                  pred_taken_if_o,
  output logic                  valid_if_o
);

  fe_types_pkg::pc_t pc_q;
  fe_types_pkg::pc_t pc_next;
  logic              redir;

  assign redir = (pc_sel_i == fe_types_pkg::PC_SEL_REDIRECT);

  // Next-PC mux
  // Predicted and redirect share one target, picked by the arbiter
  always_comb begin
    case (pc_sel_i)
      fe_types_pkg::PC_SEL_REDIRECT,
      fe_types_pkg::PC_SEL_PREDICTED: pc_next = tgt_i;
      default:                        pc_next = pc_q + 32'd4;
    endcase
  end

  // PC register
  // A redirect is taken even while stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= fe_cfg_pkg::RESET_PC;
    end else if (!stall_i || redir) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // PC/IF metadata loaded on the edge where the memory registers the read
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_if_o <= pc_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred_taken_if_o <= 1'b0;
      valid_if_o      <= 1'b0;
    end else if (redir) begin
      // Squash the read issued this cycle, or the held packet under stall
      valid_if_o <= 1'b0;
    end else if (!stall_i) begin
      pred_taken_if_o <= pred_hit_i;
      valid_if_o      <= 1'b1;
    end else if (!stall_be_i) begin
      // Port lost to the loader while decode consumed the packet
      valid_if_o <= 1'b0;
    end
  end

endmodule

/* source/fe_imem_arb.sv */
`timescale 1ns/1ps

module fe_imem_arb (
  input  logic                   fetch_en_i,
  input  fe_types_pkg::pc_t      fetch_addr_i,
  input  fe_types_pkg::load_t    load_i,
  output fe_types_pkg::mem_req_t req_o,
  output logic                   grant_fetch_o
);

  // Loader always wins the port
  assign grant_fetch_o = !load_i.we;

  always_comb begin
    req_o.en   = load_i.we || fetch_en_i;
    req_o.we   = load_i.we;
    req_o.data = load_i.data;
    if (load_i.we) begin
      req_o.addr = load_i.addr;
    end else begin
      // Byte pc to word address, upper bits beyond the memory ignored
      req_o.addr = fetch_addr_i[fe_cfg_pkg::IMEM_AW+1:2];
    end
  end

endmodule

/* source/fe_imem.sv */
`timescale 1ns/1ps

module fe_imem (
  input  logic                   clk,
  input  fe_types_pkg::mem_req_t req_i,
  output fe_types_pkg::instr_t   rdata_o
);

  fe_types_pkg::instr_t mem [fe_cfg_pkg::IMEM_WORDS];

  // Single port, write or read per cycle
  // Read data only moves on a read, a write leaves it alone
  always_ff @(posedge clk) begin
    if (req_i.en) begin
      if (req_i.we) begin
        mem[req_i.addr] <= req_i.data;
      end else begin
        rdata_o <= mem[req_i.addr];
      end
    end
  end

endmodule

/* source/fe_fetch_stage.sv */
`timescale 1ns/1ps

module fe_fetch_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stall_i,
  input  logic                     valid_if_i,
  input  fe_types_pkg::pc_t        pc_if_i,
  input  logic                     pred_taken_if_i,
  input  fe_types_pkg::instr_t     rdata_i,
  output fe_types_pkg::fetch_pkt_t fetch_o
);

  logic                 held_q;
  fe_types_pkg::instr_t hold_q;
  fe_types_pkg::instr_t instr;

  // Set from the first stalled edge until decode takes the packet
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held_q <= 1'b0;
    end else begin
      held_q <= stall_i;
    end
  end

  // Snapshot the word once, when the stall arrives
  always_ff @(posedge clk) begin
    if (stall_i && !held_q) begin
      hold_q <= rdata_i;
    end
  end

  // Held copy while stalled, live memory data otherwise
  assign instr = held_q ? hold_q : rdata_i;

  // Packet assembly
  always_comb begin
    fetch_o.valid      = valid_if_i;
    fetch_o.pc         = pc_if_i;
    fetch_o.instr      = instr;
    fetch_o.pred_taken = pred_taken_if_i;
  end

endmodule

/* source/fe_top.sv */
`timescale 1ns/1ps

module fe_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fe_types_pkg::redir_t     redir_i,
  input  fe_types_pkg::btb_upd_t   btb_upd_i,
  input  fe_types_pkg::load_t      load_i,
  input  logic                     stall_i,
  output fe_types_pkg::fetch_pkt_t fetch_o
);

  fe_types_pkg::pc_t       pc;
  fe_types_pkg::pc_t       pc_if;
  fe_types_pkg::pc_t       tgt;
  fe_types_pkg::pc_sel_t   pc_sel;
  fe_types_pkg::btb_pred_t btb_pred;
  fe_types_pkg::mem_req_t  mem_req;
  fe_types_pkg::instr_t    rdata;
  logic                    pred_taken_if;
  logic                    valid_if;
  logic                    grant_fetch;
  logic                    fetch_en;
  logic                    stall_pc;

  // PC holds on decode back-pressure or when the loader owns memory
  assign stall_pc = stall_i || !grant_fetch;
  // No fetch read while decode holds its packet
  assign fetch_en = !stall_i;

  fe_pc_sel u_pc_sel (
    .redir_i   (redir_i),
    .btb_pred_i(btb_pred),
    .pc_sel_o  (pc_sel),
    .tgt_o     (tgt)
  );

  fe_btb u_btb (
    .clk   (clk),
    .rst_n (rst_n),
    .pc_i  (pc),
    .upd_i (btb_upd_i),
    .pred_o(btb_pred)
  );

  fe_pc_stage u_pc_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall_i        (stall_pc),
    .stall_be_i     (stall_i),
    .pc_sel_i       (pc_sel),
    .tgt_i          (tgt),
    .pred_hit_i     (btb_pred.hit),
    .pc_o           (pc),
    .pc_if_o        (pc_if),
    .pred_taken_if_o(pred_taken_if),
    .valid_if_o     (valid_if)
  );

  fe_imem_arb u_imem_arb (
    .fetch_en_i   (fetch_en),
    .fetch_addr_i (pc),
    .load_i       (load_i),
    .req_o        (mem_req),
    .grant_fetch_o(grant_fetch)
  );

  fe_imem u_imem (
    .clk    (clk),
    .req_i  (mem_req),
    .rdata_o(rdata)
  );

  fe_fetch_stage u_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall_i        (stall_i),
    .valid_if_i     (valid_if),
    .pc_if_i        (pc_if),
    .pred_taken_if_i(pred_taken_if),
    .rdata_i        (rdata),
    .fetch_o        (fetch_o)
  );

endmodule

/* testbench/fe_tb.sv */
`timescale 1ns/1ps

module fe_tb;

  logic                     clk;
  logic                     rst_n;
  fe_types_pkg::redir_t     redir_i;
  fe_types_pkg::btb_upd_t   btb_upd_i;
  fe_types_pkg::load_t      load_i;
  logic                     stall_i;
  fe_types_pkg::fetch_pkt_t fetch_o;

  // Reference state
  fe_types_pkg::instr_t               ref_mem [fe_cfg_pkg::IMEM_WORDS];
  logic [fe_cfg_pkg::BTB_ENTRIES-1:0] ref_btb_valid;
  fe_types_pkg::pc_t                  ref_btb_pc [fe_cfg_pkg::BTB_ENTRIES];
  fe_types_pkg::pc_t                  ref_btb_tgt [fe_cfg_pkg::BTB_ENTRIES];
  fe_types_pkg::pc_t                  ref_pc;
  fe_types_pkg::btb_pred_t            ref_pred;

  // Expected packet
  logic                 exp_valid;
  fe_types_pkg::pc_t    exp_pc;
  fe_types_pkg::instr_t exp_instr;
  logic                 exp_pred;

  integer            seed;
  int                error_count;
  int                timeout_count;
  int                i;
  logic [31:0]       r;
  fe_types_pkg::pc_t start_pc;

  fe_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .redir_i  (redir_i),
    .btb_upd_i(btb_upd_i),
    .load_i   (load_i),
    .stall_i  (stall_i),
    .fetch_o  (fetch_o)
  );

  always #10 clk = ~clk;

  // Model BTB lookup hits when the stored word address matches
  function automatic fe_types_pkg::btb_pred_t btb_lookup(input fe_types_pkg::pc_t pc);
    logic [fe_cfg_pkg::BTB_IW-1:0] idx;
    fe_types_pkg::btb_pred_t       res;
    idx     = pc[fe_cfg_pkg::BTB_IW+1:2];
    res.hit = ref_btb_valid[idx] && (ref_btb_pc[idx][31:2] == pc[31:2]);
    res.tgt = ref_btb_tgt[idx];
    return res;
  endfunction

  always_comb begin
    ref_pred = btb_lookup(ref_pc);
  end

  // Front-end model advanced on the same edge as the DUT
  always @(posedge clk) begin
    if (load_i.we) begin
      ref_mem[load_i.addr] <= load_i.data;
    end
    if (!rst_n) begin
      ref_pc        <= fe_cfg_pkg::RESET_PC;
      exp_valid     <= 1'b0;
      ref_btb_valid <= '0;
    end else begin
      if (btb_upd_i.valid) begin
        ref_btb_valid[btb_upd_i.pc[fe_cfg_pkg::BTB_IW+1:2]] <= 1'b1;
        ref_btb_pc[btb_upd_i.pc[fe_cfg_pkg::BTB_IW+1:2]]    <= btb_upd_i.pc;
        ref_btb_tgt[btb_upd_i.pc[fe_cfg_pkg::BTB_IW+1:2]]   <= btb_upd_i.tgt;
      end
      if (redir_i.valid) begin
        // Squash the read and fetch the target next
        exp_valid <= 1'b0;
        ref_pc    <= redir_i.tgt;
      end else if (stall_i) begin
        // Whole packet and pc hold
      end else if (load_i.we) begin
        // Loader owns the port and pc holds
        exp_valid <= 1'b0;
      end else begin
        exp_valid <= 1'b1;
        exp_pc    <= ref_pc;
        exp_instr <= ref_mem[ref_pc[fe_cfg_pkg::IMEM_AW+1:2]];
        exp_pred  <= ref_pred.hit;
        ref_pc    <= ref_pred.hit ? ref_pred.tgt : ref_pc + 32'd4;
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    error_count++;
    $display("error t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
  endtask

  // Packet checks against the model on each falling edge
  valid_ok: assert property (@(negedge clk) disable iff (!rst_n)
    fetch_o.valid == exp_valid)
    else report_mismatch("fetch_o.valid", {31'd0, exp_valid}, {31'd0, fetch_o.valid});
  pc_ok: assert property (@(negedge clk) disable iff (!rst_n)
    !exp_valid || fetch_o.pc == exp_pc)
    else report_mismatch("fetch_o.pc", exp_pc, fetch_o.pc);
  instr_ok: assert property (@(negedge clk) disable iff (!rst_n)
    !exp_valid || fetch_o.instr == exp_instr)
    else report_mismatch("fetch_o.instr", exp_instr, fetch_o.instr);
  pred_ok: assert property (@(negedge clk) disable iff (!rst_n)
    !exp_valid || fetch_o.pred_taken == exp_pred)
    else report_mismatch("fetch_o.pred_taken", {31'd0, exp_pred},
                         {31'd0, fetch_o.pred_taken});

  task automatic load_word(input fe_types_pkg::waddr_t addr, input fe_types_pkg::instr_t data);
    load_i.we   = 1'b1;
    load_i.addr = addr;
    load_i.data = data;
    @(negedge clk);
    load_i.we = 1'b0;
  endtask

  task automatic redirect_to(input fe_types_pkg::pc_t tgt);
    redir_i.valid = 1'b1;
    redir_i.tgt   = tgt;
    @(negedge clk);
    redir_i.valid = 1'b0;
  endtask

  task automatic install_branch(input fe_types_pkg::pc_t pc, input fe_types_pkg::pc_t tgt);
    btb_upd_i.valid = 1'b1;
    btb_upd_i.pc    = pc;
    btb_upd_i.tgt   = tgt;
    @(negedge clk);
    btb_upd_i.valid = 1'b0;
  endtask

  // Wait for a valid packet at pc for at most limit cycles
  task automatic wait_for_pc(input fe_types_pkg::pc_t pc, input int limit);
    int cycles;
    cycles = 0;
    while (!(fetch_o.valid && fetch_o.pc == pc) && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!(fetch_o.valid && fetch_o.pc == pc)) begin
      timeout_count++;
      $display("timeout after %0d cycles waiting for a packet with pc %h", limit, pc);
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    redir_i       = '0;
    btb_upd_i     = '0;
    load_i        = '0;
    stall_i       = 1'b0;
    error_count   = 0;
    timeout_count = 0;
    seed          = 32'h9e21fcbe;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Fill memory while fetch waits behind the loader
    for (i = 0; i < fe_cfg_pkg::IMEM_WORDS; i++) begin
      load_word(i[7:0], $random(seed));
    end
    wait_for_pc(fe_cfg_pkg::RESET_PC + 32'd80, 40);

    // Stall with a loader write over the held word
    stall_i = 1'b1;
    @(negedge clk);
    load_word(exp_pc[fe_cfg_pkg::IMEM_AW+1:2], $random(seed));
    repeat (3) @(negedge clk);
    start_pc = ref_pc;
    stall_i  = 1'b0;
    wait_for_pc(start_pc + 32'd24, 20);

    // Redirect taken while stalled
    stall_i = 1'b1;
    repeat (2) @(negedge clk);
    redirect_to(32'h0000_0300);
    repeat (2) @(negedge clk);
    stall_i = 1'b0;
    wait_for_pc(32'h0000_0300, 10);
    wait_for_pc(32'h0000_0310, 10);

    // Plain redirect
    redirect_to(32'h0000_0100);
    wait_for_pc(32'h0000_0100, 10);
    wait_for_pc(32'h0000_010c, 10);

    // Branch at 0x140 to 0x200 and then 0x240 aliasing index 0 with another tag
    install_branch(32'h0000_0140, 32'h0000_0200);
    wait_for_pc(32'h0000_0140, 30);
    wait_for_pc(32'h0000_0200, 5);
    wait_for_pc(32'h0000_0240, 30);

    // Loader writes to the pc about to be fetched and to one further ahead
    start_pc = ref_pc;
    load_word(start_pc[fe_cfg_pkg::IMEM_AW+1:2], $random(seed));
    load_word(start_pc[fe_cfg_pkg::IMEM_AW+1:2] + 8'd8, $random(seed));
    wait_for_pc(start_pc, 10);
    wait_for_pc(start_pc + 32'd32, 20);

    // Random mix of stall, loader writes and redirects
    for (i = 0; i < 200; i++) begin
      r             = $random(seed);
      stall_i       = (r[1:0] == 2'd0);
      load_i.we     = (r[4:2] == 3'd0);
      load_i.addr   = r[15:8];
      load_i.data   = $random(seed);
      redir_i.valid = (r[20:17] == 4'd0);
      redir_i.tgt   = {22'd0, r[31:24], 2'b00};
      @(negedge clk);
    end
    stall_i       = 1'b0;
    load_i.we     = 1'b0;
    redir_i.valid = 1'b0;
    repeat (5) @(negedge clk);

    $display("checks done: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sim.f */
source/fe_cfg_pkg.sv
source/fe_types_pkg.sv
source/fe_pc_sel.sv
source/fe_btb.sv
source/fe_pc_stage.sv
source/fe_imem_arb.sv
source/fe_imem.sv
source/fe_fetch_stage.sv
source/fe_top.sv
testbench/fe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module fe_tb -f sim.f -o fe_tb_sim
./obj_dir/fe_tb_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation PASS"
  exit 0
else
  echo "Simulation FAIL"
  exit 1
fi
